// File: source/cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// datapath widths
`define CPU_WORD_W      32
`define CPU_REG_IDX_W   5

// memories, word addressed
`define CPU_IMEM_DEPTH  256
`define CPU_DMEM_DEPTH  256
`define CPU_MEM_ADDR_W  8       // log2 of depth

// opcodes, instr[31:26]
`define CPU_OP_RTYPE    6'h00
`define CPU_OP_J        6'h02
`define CPU_OP_BEQ      6'h04
`define CPU_OP_BNE      6'h05
`define CPU_OP_ADDI     6'h08
`define CPU_OP_LW       6'h23
`define CPU_OP_SW       6'h2b

// r-type function codes, instr[5:0]
`define CPU_FN_ADD      6'h20
`define CPU_FN_SUB      6'h22
`define CPU_FN_AND      6'h24
`define CPU_FN_OR       6'h25
`define CPU_FN_SLT      6'h2a

`endif

// File: source/cpu_pkg.sv
`default_nettype none
`include "cpu_params.svh"

package cpu_pkg;

    typedef logic [`CPU_WORD_W-1:0]    word_t;     // data / instruction word
    typedef logic [`CPU_REG_IDX_W-1:0] reg_idx_t;  // gpr index
    typedef logic [`CPU_WORD_W-1:0]    pc_t;       // byte address

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT    // signed compare
    } alu_op_e;

    // operand source picked in execute
    typedef enum logic [1:0] {
        FWD_REG,   // value read in decode
        FWD_MEM,   // alu result sitting in ex/mem
        FWD_WB     // writeback data
    } fwd_sel_e;

    // decoded control, all flags already qualified by valid
    typedef struct packed {
        logic    valid;
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    branch_eq;
        logic    branch_ne;
        logic    jump;
        logic    use_imm;     // operand b from immediate
        alu_op_e alu_op;
    } ctrl_t;

    typedef struct packed {
        ctrl_t    ctrl;
        pc_t      pc;
        word_t    rs_val;
        word_t    rt_val;
        word_t    imm;          // sign extended
        reg_idx_t rs;           // zero when not a real source
        reg_idx_t rt;
        reg_idx_t dst;
        pc_t      jump_target;
    } id_ex_t;

    typedef struct packed {
        logic     valid;
        logic     reg_write;
        logic     mem_read;
        logic     mem_write;
        word_t    alu_result;   // also the load/store address
        word_t    store_data;
        reg_idx_t dst;
    } ex_mem_t;

    typedef struct packed {
        logic     valid;        // only for writes to r1..r31
        reg_idx_t dst;
        word_t    data;
    } wb_t;

endpackage

`default_nettype wire

// File: source/fetch_unit.sv
`timescale 1ns/10ps
`default_nettype none
`include "cpu_params.svh"

module fetch_unit (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        prog_we,
    input  wire [`CPU_MEM_ADDR_W-1:0]  prog_addr,
    input  cpu_pkg::word_t             prog_data,
    input  wire                        stall,
    input  wire                        flush,
    input  wire                        redirect,
    input  cpu_pkg::pc_t               redirect_pc,
    output cpu_pkg::word_t             id_instr,
    output cpu_pkg::pc_t               id_pc,
    output logic                       id_valid
);

    cpu_pkg::pc_t               pc;
    cpu_pkg::word_t             imem [`CPU_IMEM_DEPTH];
    logic [`CPU_MEM_ADDR_W-1:0] fetch_idx;

    assign fetch_idx = pc[`CPU_MEM_ADDR_W+1:2];    // word index, byte offset dropped

    // loader port, only live while the core sits in reset
    always_ff @(posedge clk) begin
        if (!rst_n && prog_we) begin
            imem[prog_addr] <= prog_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc       <= '0;
            id_valid <= 1'b0;
        end else begin
            if (redirect)
                pc <= redirect_pc;          // taken branch / jump from execute
            else if (!stall)
                pc <= pc + 32'd4;
            if (flush)
                id_valid <= 1'b0;           // kill the wrong-path word
            else if (!stall)
                id_valid <= 1'b1;
        end
    end

    // if/id payload, held on stall
    always_ff @(posedge clk) begin
        if (!stall) begin
            id_instr <= imem[fetch_idx];
            id_pc    <= pc;
        end
    end

endmodule

`default_nettype wire

// File: source/register_file.sv
`timescale 1ns/10ps
`default_nettype none
`include "cpu_params.svh"

module register_file (
    input  wire                   clk,
    input  wire                   rst_n,
    input  cpu_pkg::reg_idx_t     rd_idx_a,
    input  cpu_pkg::reg_idx_t     rd_idx_b,
    input  cpu_pkg::wb_t          wb,
    output cpu_pkg::word_t        rd_data_a,
    output cpu_pkg::word_t        rd_data_b
);

    cpu_pkg::word_t regs [1 << `CPU_REG_IDX_W];

    // architectural state starts at zero
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < (1 << `CPU_REG_IDX_W); i++)
                regs[i] <= '0;
        end else if (wb.valid && wb.dst != '0) begin
            regs[wb.dst] <= wb.data;    // r0 never written
        end
    end

    // r0 reads zero, same-cycle write passes straight through
    assign rd_data_a = (rd_idx_a == '0) ? '0 :
                       (wb.valid && wb.dst == rd_idx_a) ? wb.data : regs[rd_idx_a];
    assign rd_data_b = (rd_idx_b == '0) ? '0 :
                       (wb.valid && wb.dst == rd_idx_b) ? wb.data : regs[rd_idx_b];

endmodule

`default_nettype wire

// File: source/pipeline_control.sv
`timescale 1ns/10ps
`default_nettype none
`include "cpu_params.svh"

module pipeline_control (
    input  cpu_pkg::word_t      id_instr,
    input  cpu_pkg::pc_t        id_pc,
    input  wire                 id_valid,
    input  cpu_pkg::word_t      rd_data_a,
    input  cpu_pkg::word_t      rd_data_b,
    input  cpu_pkg::id_ex_t     ex_stage,
    input  cpu_pkg::ex_mem_t    mem_stage,
    input  cpu_pkg::wb_t        wb,
    input  wire                 redirect,
    output cpu_pkg::reg_idx_t   rd_idx_a,
    output cpu_pkg::reg_idx_t   rd_idx_b,
    output cpu_pkg::id_ex_t     id_out,
    output logic                stall,
    output logic                flush,
    output cpu_pkg::fwd_sel_e   fwd_a,
    output cpu_pkg::fwd_sel_e   fwd_b,
    output cpu_pkg::fwd_sel_e   fwd_store
);

    logic [5:0]         opcode;
    logic [5:0]         funct;
    cpu_pkg::reg_idx_t  rs;
    cpu_pkg::reg_idx_t  rt;
    cpu_pkg::reg_idx_t  rd;
    cpu_pkg::reg_idx_t  dst;
    cpu_pkg::ctrl_t     ctrl;
    cpu_pkg::pc_t       pc_plus4;
    logic               uses_rs;
    logic               uses_rt;

    // mem stage wins over writeback, r0 is never forwarded
    function automatic cpu_pkg::fwd_sel_e pick_src(input cpu_pkg::reg_idx_t src,
                                                   input logic en);
        cpu_pkg::fwd_sel_e sel;
        sel = cpu_pkg::FWD_REG;
        if (en && src != '0) begin
            if (mem_stage.reg_write && mem_stage.dst == src)
                sel = cpu_pkg::FWD_MEM;
            else if (wb.valid && wb.dst == src)
                sel = cpu_pkg::FWD_WB;
        end
        return sel;
    endfunction

    assign opcode   = id_instr[31:26];
    assign rs       = id_instr[25:21];
    assign rt       = id_instr[20:16];
    assign rd       = id_instr[15:11];
    assign funct    = id_instr[5:0];
    assign pc_plus4 = id_pc + 32'd4;

    always_comb begin
        ctrl        = '0;
        ctrl.valid  = id_valid;
        ctrl.alu_op = cpu_pkg::ALU_ADD;
        dst         = rt;               // i-type writes rt
        uses_rs     = 1'b0;
        uses_rt     = 1'b0;
        case (opcode)
            `CPU_OP_RTYPE: begin
                dst            = rd;
                uses_rs        = 1'b1;
                uses_rt        = 1'b1;
                ctrl.reg_write = 1'b1;
                case (funct)
                    `CPU_FN_ADD: ctrl.alu_op = cpu_pkg::ALU_ADD;
                    `CPU_FN_SUB: ctrl.alu_op = cpu_pkg::ALU_SUB;
                    `CPU_FN_AND: ctrl.alu_op = cpu_pkg::ALU_AND;
                    `CPU_FN_OR:  ctrl.alu_op = cpu_pkg::ALU_OR;
                    `CPU_FN_SLT: ctrl.alu_op = cpu_pkg::ALU_SLT;
                    default:     ctrl.reg_write = 1'b0;  // nop word lands here
                endcase
            end
            `CPU_OP_ADDI: begin
                uses_rs        = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.use_imm   = 1'b1;
            end
            `CPU_OP_LW: begin
                uses_rs        = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.mem_read  = 1'b1;
                ctrl.use_imm   = 1'b1;
            end
            `CPU_OP_SW: begin
                uses_rs        = 1'b1;
                uses_rt        = 1'b1;  // store data
                ctrl.mem_write = 1'b1;
                ctrl.use_imm   = 1'b1;
            end
            `CPU_OP_BEQ, `CPU_OP_BNE: begin
                uses_rs        = 1'b1;
                uses_rt        = 1'b1;
                ctrl.branch_eq = (opcode == `CPU_OP_BEQ);
                ctrl.branch_ne = (opcode == `CPU_OP_BNE);
            end
            `CPU_OP_J:   ctrl.jump = 1'b1;
            default:     ;                       // unknown opcode retires as nop
        endcase
        if (!id_valid)
            ctrl = '0;                           // empty slot carries nothing
    end

    assign rd_idx_a = uses_rs ? rs : '0;        // unused source reads as r0
    assign rd_idx_b = uses_rt ? rt : '0;

    always_comb begin
        id_out             = '0;
        id_out.ctrl        = ctrl;
        id_out.pc          = id_pc;
        id_out.rs_val      = rd_data_a;
        id_out.rt_val      = rd_data_b;
        id_out.imm         = {{(`CPU_WORD_W-16){id_instr[15]}}, id_instr[15:0]};
        id_out.rs          = rd_idx_a;
        id_out.rt          = rd_idx_b;
        id_out.dst         = dst;
        id_out.jump_target = {pc_plus4[31:28], id_instr[25:0], 2'b00};
    end

    // load in execute feeding the word in decode, one bubble
    assign stall = id_valid && ex_stage.ctrl.mem_read && ex_stage.dst != '0 &&
                   (ex_stage.dst == rd_idx_a || ex_stage.dst == rd_idx_b);
    assign flush = redirect;

    always_comb begin
        fwd_a     = pick_src(ex_stage.rs, 1'b1);
        fwd_b     = pick_src(ex_stage.rt, !ex_stage.ctrl.use_imm);   // register operand b
        fwd_store = pick_src(ex_stage.rt, ex_stage.ctrl.mem_write);
    end

endmodule

`default_nettype wire

// File: source/execute_unit.sv
`timescale 1ns/10ps
`default_nettype none

module execute_unit (
    input  wire                 clk,
    input  wire                 rst_n,
    input  cpu_pkg::id_ex_t     id_in,
    input  wire                 stall,
    input  wire                 flush,
    input  cpu_pkg::fwd_sel_e   fwd_a,
    input  cpu_pkg::fwd_sel_e   fwd_b,
    input  cpu_pkg::fwd_sel_e   fwd_store,
    input  cpu_pkg::ex_mem_t    mem_stage,
    input  cpu_pkg::wb_t        wb,
    output cpu_pkg::id_ex_t     ex_stage,
    output cpu_pkg::ex_mem_t    ex_out,
    output logic                redirect,
    output cpu_pkg::pc_t        redirect_pc
);

    cpu_pkg::word_t op_a;
    cpu_pkg::word_t rt_fwd;     // forwarded rt, also branch compare
    cpu_pkg::word_t op_b;
    cpu_pkg::word_t store_val;
    cpu_pkg::word_t alu_y;
    logic           taken;

    function automatic cpu_pkg::word_t fwd_mux(input cpu_pkg::fwd_sel_e sel,
                                               input cpu_pkg::word_t reg_val);
        case (sel)
            cpu_pkg::FWD_MEM: return mem_stage.alu_result;
            cpu_pkg::FWD_WB:  return wb.data;
            default:          return reg_val;
        endcase
    endfunction

    // id/ex register, control zeroed for a bubble
    always_ff @(posedge clk) begin
        ex_stage <= id_in;
        if (!rst_n || stall || flush)
            ex_stage.ctrl <= '0;
    end

    always_comb begin
        op_a      = fwd_mux(fwd_a, ex_stage.rs_val);
        rt_fwd    = fwd_mux(fwd_b, ex_stage.rt_val);
        store_val = fwd_mux(fwd_store, ex_stage.rt_val);
        op_b      = ex_stage.ctrl.use_imm ? ex_stage.imm : rt_fwd;
    end

    always_comb begin
        case (ex_stage.ctrl.alu_op)
            cpu_pkg::ALU_SUB: alu_y = op_a - op_b;
            cpu_pkg::ALU_AND: alu_y = op_a & op_b;
            cpu_pkg::ALU_OR:  alu_y = op_a | op_b;
            cpu_pkg::ALU_SLT: alu_y = {31'd0, $signed(op_a) < $signed(op_b)};
            default:          alu_y = op_a + op_b;      // add, addi, address calc
        endcase
    end

    // branch / jump resolution
    assign taken = (ex_stage.ctrl.branch_eq && op_a == rt_fwd) ||
                   (ex_stage.ctrl.branch_ne && op_a != rt_fwd) ||
                   ex_stage.ctrl.jump;
    assign redirect    = taken;     // flags are valid-qualified, so one cycle only
    assign redirect_pc = ex_stage.ctrl.jump ? ex_stage.jump_target :
                         ex_stage.pc + 32'd4 + (ex_stage.imm << 2);

    always_comb begin
        ex_out.valid      = ex_stage.ctrl.valid;
        ex_out.reg_write  = ex_stage.ctrl.reg_write;
        ex_out.mem_read   = ex_stage.ctrl.mem_read;
        ex_out.mem_write  = ex_stage.ctrl.mem_write;
        ex_out.alu_result = alu_y;
        ex_out.store_data = store_val;
        ex_out.dst        = ex_stage.dst;
    end

endmodule

`default_nettype wire

// File: source/memory_unit.sv
`timescale 1ns/10ps
`default_nettype none
`include "cpu_params.svh"

module memory_unit (
    input  wire                 clk,
    input  wire                 rst_n,
    input  cpu_pkg::ex_mem_t    ex_in,
    output cpu_pkg::ex_mem_t    mem_stage,
    output cpu_pkg::wb_t        wb
);

    cpu_pkg::word_t             dmem [`CPU_DMEM_DEPTH];
    logic [`CPU_MEM_ADDR_W-1:0] dmem_idx;
    cpu_pkg::word_t             load_data;

    assign dmem_idx  = mem_stage.alu_result[`CPU_MEM_ADDR_W+1:2];  // word select, bits 9:2
    assign load_data = dmem[dmem_idx];                           // async read

    // ex/mem register
    always_ff @(posedge clk) begin
        mem_stage <= ex_in;
        if (!rst_n) begin
            mem_stage.valid     <= 1'b0;
            mem_stage.reg_write <= 1'b0;
            mem_stage.mem_read  <= 1'b0;
            mem_stage.mem_write <= 1'b0;
        end
    end

    // data memory comes up zeroed
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `CPU_DMEM_DEPTH; i++)
                dmem[i] <= '0;
        end else if (mem_stage.valid && mem_stage.mem_write) begin
            dmem[dmem_idx] <= mem_stage.store_data;
        end
    end

    // mem/wb register
    always_ff @(posedge clk) begin
        if (!rst_n)
            wb.valid <= 1'b0;
        else
            wb.valid <= mem_stage.valid && mem_stage.reg_write &&
                        mem_stage.dst != '0;    // r0 writes dropped here
    end

    always_ff @(posedge clk) begin
        wb.dst  <= mem_stage.dst;
        wb.data <= mem_stage.mem_read ? load_data : mem_stage.alu_result;
    end

endmodule

`default_nettype wire

// File: source/cpu_top.sv
`timescale 1ns/10ps
`default_nettype none
`include "cpu_params.svh"

module cpu_top (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        prog_we,
    input  wire [`CPU_MEM_ADDR_W-1:0]  prog_addr,
    input  cpu_pkg::word_t             prog_data,
    output cpu_pkg::wb_t               wb_out
);

    cpu_pkg::word_t     id_instr;       // if/id
    cpu_pkg::pc_t       id_pc;
    logic               id_valid;
    cpu_pkg::reg_idx_t  rd_idx_a;
    cpu_pkg::reg_idx_t  rd_idx_b;
    cpu_pkg::word_t     rd_data_a;
    cpu_pkg::word_t     rd_data_b;
    cpu_pkg::id_ex_t    id_out;         // decode result into id/ex
    cpu_pkg::id_ex_t    ex_stage;       // registered id/ex
    cpu_pkg::ex_mem_t   ex_out;
    cpu_pkg::ex_mem_t   mem_stage;
    cpu_pkg::wb_t       wb;
    logic               stall;
    logic               flush;
    logic               redirect;
    cpu_pkg::pc_t       redirect_pc;
    cpu_pkg::fwd_sel_e  fwd_a;
    cpu_pkg::fwd_sel_e  fwd_b;
    cpu_pkg::fwd_sel_e  fwd_store;

    fetch_unit u_fetch (
        .clk(clk), .rst_n(rst_n),
        .prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data),
        .stall(stall), .flush(flush), .redirect(redirect), .redirect_pc(redirect_pc),
        .id_instr(id_instr), .id_pc(id_pc), .id_valid(id_valid)
    );

    register_file u_regs (
        .clk(clk), .rst_n(rst_n),
        .rd_idx_a(rd_idx_a), .rd_idx_b(rd_idx_b), .wb(wb),
        .rd_data_a(rd_data_a), .rd_data_b(rd_data_b)
    );

    pipeline_control u_ctrl (
        .id_instr(id_instr), .id_pc(id_pc), .id_valid(id_valid),
        .rd_data_a(rd_data_a), .rd_data_b(rd_data_b),
        .ex_stage(ex_stage), .mem_stage(mem_stage), .wb(wb), .redirect(redirect),
        .rd_idx_a(rd_idx_a), .rd_idx_b(rd_idx_b), .id_out(id_out),
        .stall(stall), .flush(flush),
        .fwd_a(fwd_a), .fwd_b(fwd_b), .fwd_store(fwd_store)
    );

    execute_unit u_exec (
        .clk(clk), .rst_n(rst_n), .id_in(id_out), .stall(stall), .flush(flush),
        .fwd_a(fwd_a), .fwd_b(fwd_b), .fwd_store(fwd_store),
        .mem_stage(mem_stage), .wb(wb),
        .ex_stage(ex_stage), .ex_out(ex_out),
        .redirect(redirect), .redirect_pc(redirect_pc)
    );

    memory_unit u_mem (
        .clk(clk), .rst_n(rst_n), .ex_in(ex_out),
        .mem_stage(mem_stage), .wb(wb)
    );

    assign wb_out = wb;     // retirement bus

endmodule

`default_nettype wire

// File: tb/cpu_model.svh
`ifndef CPU_MODEL_SVH
`define CPU_MODEL_SVH

// included inside tb_cpu and works on its prog, prog_len and exp_q

logic [31:0] rng_state = 32'd56;

// xorshift32 step
function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
endfunction

function automatic cpu_pkg::reg_idx_t pick_reg();
    logic [31:0] r;
    r = next_rand();
    return {2'b00, r[2:0]};     // r0..r7 only so dependences stay dense
endfunction

function automatic logic [5:0] pick_funct();
    case (next_rand() % 5)
        0:       return `CPU_FN_ADD;
        1:       return `CPU_FN_SUB;
        2:       return `CPU_FN_AND;
        3:       return `CPU_FN_OR;
        default: return `CPU_FN_SLT;
    endcase
endfunction

function automatic cpu_pkg::word_t rtype_word(input logic [5:0] funct,
                                              input cpu_pkg::reg_idx_t rd,
                                              input cpu_pkg::reg_idx_t rs,
                                              input cpu_pkg::reg_idx_t rt);
    return {`CPU_OP_RTYPE, rs, rt, rd, 5'd0, funct};
endfunction

function automatic cpu_pkg::word_t itype_word(input logic [5:0] op,
                                              input cpu_pkg::reg_idx_t rt,
                                              input cpu_pkg::reg_idx_t rs,
                                              input logic [15:0] imm);
    return {op, rs, rt, imm};
endfunction

function automatic void emit(input cpu_pkg::word_t w);
    prog[prog_len] = w;     // append to the program image
    prog_len++;
endfunction

function automatic void alu_chain_program();
    prog_len = 0;
    emit(itype_word(`CPU_OP_ADDI, 5'd1, 5'd0, 16'd5));
    emit(itype_word(`CPU_OP_ADDI, 5'd2, 5'd0, -16'sd3));
    emit(rtype_word(`CPU_FN_ADD, 5'd3, 5'd1, 5'd2));     // r2 from mem stage and r1 from wb
    emit(rtype_word(`CPU_FN_SUB, 5'd4, 5'd3, 5'd1));
    emit(rtype_word(`CPU_FN_AND, 5'd5, 5'd4, 5'd3));
    emit(rtype_word(`CPU_FN_OR, 5'd6, 5'd5, 5'd4));
    emit(rtype_word(`CPU_FN_SLT, 5'd7, 5'd4, 5'd1));     // negative below positive
    emit(rtype_word(`CPU_FN_SLT, 5'd8, 5'd1, 5'd4));
    emit(itype_word(`CPU_OP_ADDI, 5'd9, 5'd7, -16'sd100));
    emit(rtype_word(`CPU_FN_ADD, 5'd0, 5'd9, 5'd9));     // r0 target never retires
    emit(rtype_word(`CPU_FN_ADD, 5'd10, 5'd9, 5'd0));
endfunction

function automatic void store_load_program();
    prog_len = 0;
    emit(itype_word(`CPU_OP_ADDI, 5'd1, 5'd0, 16'h0040));  // base at word 16
    emit(itype_word(`CPU_OP_ADDI, 5'd2, 5'd0, 16'h1234));
    emit(itype_word(`CPU_OP_SW, 5'd2, 5'd1, 16'd0));       // store data forwarded
    emit(itype_word(`CPU_OP_ADDI, 5'd3, 5'd0, -16'sd7));
    emit(itype_word(`CPU_OP_SW, 5'd3, 5'd1, 16'd4));
    emit(itype_word(`CPU_OP_LW, 5'd4, 5'd1, 16'd0));
    emit(itype_word(`CPU_OP_LW, 5'd5, 5'd1, 16'd4));
    emit(itype_word(`CPU_OP_LW, 5'd6, 5'd1, 16'd8));       // never stored so reads zero
    emit(itype_word(`CPU_OP_SW, 5'd5, 5'd1, -16'sd4));     // load data via wb into word 15
    emit(itype_word(`CPU_OP_LW, 5'd7, 5'd0, 16'h003c));
endfunction

function automatic void load_use_program();
    prog_len = 0;
    emit(itype_word(`CPU_OP_ADDI, 5'd1, 5'd0, 16'd21));
    emit(itype_word(`CPU_OP_SW, 5'd1, 5'd0, 16'd8));
    emit(itype_word(`CPU_OP_ADDI, 5'd2, 5'd0, 16'd100));
    emit(itype_word(`CPU_OP_LW, 5'd3, 5'd0, 16'd8));
    emit(rtype_word(`CPU_FN_ADD, 5'd4, 5'd3, 5'd2));      // one bubble here
    emit(itype_word(`CPU_OP_LW, 5'd5, 5'd0, 16'd8));
    emit(rtype_word(`CPU_FN_SUB, 5'd6, 5'd2, 5'd5));      // load on operand b
    emit(itype_word(`CPU_OP_LW, 5'd7, 5'd4, -16'sd113));  // 121 - 113 gives word 2 again
    emit(itype_word(`CPU_OP_SW, 5'd7, 5'd0, 16'd12));     // load into store data
    emit(itype_word(`CPU_OP_LW, 5'd8, 5'd0, 16'd12));
endfunction

function automatic void branch_program();
    prog_len = 0;
    emit(itype_word(`CPU_OP_ADDI, 5'd1, 5'd0, 16'd1));
    emit(itype_word(`CPU_OP_ADDI, 5'd2, 5'd0, 16'd1));
    emit(itype_word(`CPU_OP_BEQ, 5'd2, 5'd1, 16'd2));     // taken to word 5
    emit(itype_word(`CPU_OP_ADDI, 5'd3, 5'd0, 16'd111));
    emit(itype_word(`CPU_OP_ADDI, 5'd3, 5'd0, 16'd222));
    emit(itype_word(`CPU_OP_BNE, 5'd2, 5'd1, 16'd1));     // not taken
    emit(itype_word(`CPU_OP_ADDI, 5'd4, 5'd0, 16'd4));
    emit(itype_word(`CPU_OP_BNE, 5'd0, 5'd1, 16'd2));     // taken to word 10
    emit(itype_word(`CPU_OP_ADDI, 5'd5, 5'd0, 16'd55));
    emit(itype_word(`CPU_OP_ADDI, 5'd5, 5'd0, 16'd66));
    emit({`CPU_OP_J, 26'd13});
    emit(itype_word(`CPU_OP_ADDI, 5'd6, 5'd0, 16'd11));
    emit(itype_word(`CPU_OP_ADDI, 5'd6, 5'd0, 16'd12));
    emit(itype_word(`CPU_OP_BEQ, 5'd0, 5'd1, 16'd1));     // not taken
    emit(itype_word(`CPU_OP_ADDI, 5'd7, 5'd0, 16'd7));
endfunction

// forward-only control flow with loads and stores on words 0..63
function automatic void random_program(input int n);
    logic [31:0]       r;
    cpu_pkg::reg_idx_t rd;
    cpu_pkg::reg_idx_t rs;
    cpu_pkg::reg_idx_t rt;
    int                i;
    prog_len = 0;
    for (i = 0; i < n; i++) begin
        rd = pick_reg();
        rs = pick_reg();
        rt = pick_reg();
        r  = next_rand();
        case (r % 10)
            0, 1, 2, 3, 4: emit(rtype_word(pick_funct(), rd, rs, rt));
            5: emit(itype_word(`CPU_OP_ADDI, rt, rs, r[31:16]));
            6: emit(itype_word(`CPU_OP_LW, rt, 5'd0, {8'd0, r[21:16], 2'b00}));
            7: emit(itype_word(`CPU_OP_SW, rt, 5'd0, {8'd0, r[21:16], 2'b00}));
            8: emit(itype_word(r[16] ? `CPU_OP_BNE : `CPU_OP_BEQ, rt, rs, {14'd0, r[18:17]}));
            default: emit({`CPU_OP_J, 26'(i + 1 + int'(r[17:16]))});
        endcase
    end
endfunction

// architectural run of prog with one queue entry per register write
function automatic void run_model(input int max_steps);
    cpu_pkg::word_t    regs [32];
    cpu_pkg::word_t    dmem [`CPU_DMEM_DEPTH];
    cpu_pkg::word_t    ins;
    cpu_pkg::word_t    a;
    cpu_pkg::word_t    b;
    cpu_pkg::word_t    imm;
    cpu_pkg::word_t    addr;
    cpu_pkg::word_t    res;
    cpu_pkg::pc_t      pc;
    cpu_pkg::pc_t      next_pc;
    cpu_pkg::reg_idx_t dst;
    cpu_pkg::wb_t      ev;
    logic              wr;
    int                widx;
    int                i;
    for (i = 0; i < 32; i++)
        regs[i] = '0;
    for (i = 0; i < `CPU_DMEM_DEPTH; i++)
        dmem[i] = '0;
    pc = '0;
    for (i = 0; i < max_steps; i++) begin
        widx    = int'(pc[`CPU_MEM_ADDR_W+1:2]);
        ins     = (widx < prog_len) ? prog[widx] : '0;  // loaded image is no-ops past prog_len
        a       = regs[ins[25:21]];
        b       = regs[ins[20:16]];
        imm     = {{16{ins[15]}}, ins[15:0]};
        addr    = a + imm;              // byte address for lw / sw
        next_pc = pc + 32'd4;
        dst     = ins[20:16];
        wr      = 1'b0;
        res     = '0;
        case (ins[31:26])
            `CPU_OP_RTYPE: begin
                dst = ins[15:11];
                wr  = 1'b1;
                case (ins[5:0])
                    `CPU_FN_ADD: res = a + b;
                    `CPU_FN_SUB: res = a - b;
                    `CPU_FN_AND: res = a & b;
                    `CPU_FN_OR:  res = a | b;
                    `CPU_FN_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default:     wr = 1'b0;     // all-zero word
                endcase
            end
            `CPU_OP_ADDI: begin
                res = a + imm;
                wr  = 1'b1;
            end
            `CPU_OP_LW: begin
                res = dmem[addr[9:2]];
                wr  = 1'b1;
            end
            `CPU_OP_SW:  dmem[addr[9:2]] = b;
            `CPU_OP_BEQ: if (a == b) next_pc = next_pc + (imm << 2);
            `CPU_OP_BNE: if (a != b) next_pc = next_pc + (imm << 2);
            `CPU_OP_J:   next_pc = {next_pc[31:28], ins[25:0], 2'b00};
            default:     ;
        endcase
        if (wr && dst != '0) begin
            regs[dst] = res;
            ev.valid  = 1'b1;
            ev.dst    = dst;
            ev.data   = res;
            exp_q.push_back(ev);
        end
        pc = next_pc;
    end
endfunction

`endif

// File: tb/tb_cpu.sv
`timescale 1ns/10ps
`default_nettype none
`include "cpu_params.svh"

module tb_cpu;

    localparam int MODEL_STEPS  = 200;  // stays below the 256-word pc wrap
    localparam int RANDOM_TESTS = 20;
    localparam int RANDOM_LEN   = 40;

    logic                       clk = 1'b0;
    logic                       rst_n;
    logic                       prog_we;
    logic [`CPU_MEM_ADDR_W-1:0] prog_addr;
    cpu_pkg::word_t             prog_data;
    cpu_pkg::wb_t               wb_out;

    cpu_pkg::word_t prog [`CPU_IMEM_DEPTH];     // program image of the current test
    int             prog_len;
    cpu_pkg::wb_t   exp_q [$];                  // expected retirements, in order
    logic           rst_q       = 1'b0;         // reset as seen by the DUT last edge
    int             run_cycles  = 0;            // cycles out of reset, all tests
    int             cycle_limit = 200;
    int             errors      = 0;
    int             checks      = 0;
    int             tests       = 0;
    int             failed      = 0;

    `include "cpu_model.svh"

    cpu_top DUT (
        .clk(clk), .rst_n(rst_n),
        .prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data),
        .wb_out(wb_out)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        rst_q <= rst_n;
        if (rst_n)
            run_cycles <= run_cycles + 1;
        if (run_cycles >= cycle_limit) begin
            $display("simulation timed out after %0d cycles out of reset (limit %0d)",
                     run_cycles, cycle_limit);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // compare on the falling edge, wb_out settled since the rising one
    always @(negedge clk) begin
        cpu_pkg::wb_t want;
        if (!rst_q) begin
            assert (wb_out.valid !== 1'b1) else begin
                $display("error at %0t: writeback raised while the core was in reset", $time);
                errors++;
            end
        end else if (wb_out.valid) begin
            assert (exp_q.size() != 0) else begin
                $display("error at %0t: writeback to r%0d when none was expected",
                         $time, wb_out.dst);
                errors++;
            end
            if (exp_q.size() != 0) begin
                want = exp_q.pop_front();
                checks++;
                assert (wb_out.dst == want.dst && wb_out.data == want.data) else begin
                    $display("[FAIL] %0t: writeback r%0d = %h, expected r%0d = %h", $time,
                             wb_out.dst, wb_out.data, want.dst, want.data);
                    errors++;
                end
            end
        end
    end

    // called on a rising edge, returns on one
    task automatic run_test(input string name);
        int err0;
        int chk0;
        int i;
        err0 = errors;
        chk0 = checks;
        rst_n <= 1'b0;
        repeat (5) @(posedge clk);
        for (i = 0; i < `CPU_IMEM_DEPTH; i++) begin
            prog_we   <= 1'b1;
            prog_addr <= i[`CPU_MEM_ADDR_W-1:0];
            prog_data <= (i < prog_len) ? prog[i] : '0;     // no-op fill past the end
            @(posedge clk);
        end
        prog_we <= 1'b0;
        run_model(MODEL_STEPS);
        cycle_limit <= cycle_limit + prog_len * 3;
        rst_n       <= 1'b1;
        while (exp_q.size() != 0)
            @(posedge clk);
        repeat (10) @(posedge clk);     // quiet window for stray writebacks
        tests++;
        if (errors != err0)
            failed++;
        $display("test %s: %0d writebacks checked, %0d errors", name,
                 checks - chk0, errors - err0);
    endtask

    initial begin
        int k;
        rst_n     = 1'b0;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        @(posedge clk);
        alu_chain_program();
        run_test("alu_chain");
        store_load_program();
        run_test("store_load");
        load_use_program();
        run_test("load_use");
        branch_program();
        run_test("branches");
        prog_len = 0;                   // nothing but no-ops
        run_test("idle");
        for (k = 0; k < RANDOM_TESTS; k++) begin
            random_program(RANDOM_LEN);
            run_test($sformatf("random_%0d", k));
        end
        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests, failed, checks, errors);
        if (errors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+source
+incdir+tb
source/cpu_pkg.sv
source/fetch_unit.sv
source/register_file.sv
source/pipeline_control.sv
source/execute_unit.sv
source/memory_unit.sv
source/cpu_top.sv
tb/tb_cpu.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the pipeline core testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert -j 0 --top-module tb_cpu -f sources.f -o sim_cpu

./obj_dir/sim_cpu | tee sim.log

if grep -q "\*\*\* TEST PASSED \*\*\*" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi
